/* design/vmem_pkg.sv */
// Two-lane vector memory types; 1 KiB scratchpad, byte address bits above bit 9 are ignored
package vmem_pkg;

  // Data and address width
  localparam int XLEN = 32;

  // Element lanes per request
  localparam int LANES = 2;

  // Scratchpad depth in words and its word index width
  localparam int MEM_WORDS = 256;
  localparam int MEM_AW    = $clog2(MEM_WORDS);

  // Element width
  typedef enum logic [1:0] {
    E8  = 2'd0,
    E16 = 2'd1,
    E32 = 2'd2
  } eew_t;

  // Request kind
  typedef enum logic [1:0] {
    OP_ALU   = 2'd0,
    OP_LOAD  = 2'd1,
    OP_STORE = 2'd2,
    OP_CFG   = 2'd3
  } vop_t;

  // Execute to memory request
  typedef struct packed {
    vop_t                       op;
    // Byte address for load/store, result for ALU
    logic [LANES-1:0][XLEN-1:0] lane_val;
    logic [LANES-1:0][XLEN-1:0] st_data;
    // Element index of lane 0
    logic [7:0]                 ls_idx;
    logic [4:0]                 vd;
    logic [7:0]                 cfg_vl;
    eew_t                       cfg_eew;
  } vmem_req_t;

  // Per-lane notice from the scheduler to the aligner
  typedef struct packed {
    logic             lane;
    logic [1:0]       offset;
    eew_t             eew;
    logic             load;
    logic             last;
    // Lanes this notice writes back
    logic [LANES-1:0] wen;
    // Misaligned lane or slave error
    logic             exc;
  } vmem_elem_t;

  // Writeback record
  typedef struct packed {
    logic [4:0]                 vd;
    logic [LANES-1:0][XLEN-1:0] data;
    logic [LANES-1:0]           wen;
    eew_t                       eew;
    logic                       exc;
  } vmem_wb_t;

endpackage

/* design/vmem_addr_sched.sv */
// Lane 0 is accessed first; misaligned active lanes are skipped, not split
`timescale 1ns/10ps

module vmem_addr_sched (
  input  logic                 CLK,
  input  logic                 nRST,
  input  vmem_pkg::vmem_req_t  req,
  input  logic                 req_valid,
  output logic                 busy,
  input  logic                 flush,
  input  logic                 hold,
  output logic                 psel,
  output logic                 penable,
  output logic                 pwrite,
  output logic [31:0]          paddr,
  output logic [31:0]          pwdata,
  output logic [3:0]           pstrb,
  input  logic [31:0]          prdata,
  input  logic                 pready,
  input  logic                 pslverr,
  output vmem_pkg::vmem_elem_t elem,
  output logic                 elem_valid,
  output logic [1:0][31:0]     lane_data,
  output logic [4:0]           vd_out
);
  import vmem_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    NOTIFY,
    PREP,
    SETUP,
    ACCESS
  } state_t;

  state_t           state;
  state_t           next_state;
  vmem_req_t        req_q;
  logic [7:0]       vl_q;
  eew_t             eew_q;
  // Lane 1 has a transfer of its own
  logic             acc_q;
  logic             exc_q;
  logic             lane_q;
  logic             accept;
  logic             is_mem;
  logic [LANES-1:0] act_in;
  logic [LANES-1:0] mis_in;
  logic [LANES-1:0] acc_in;
  logic [2:0]       elem_size;
  logic [3:0]       elem_mask;
  logic             nxt_lane;
  logic [1:0]       nxt_off;
  logic             last_access;

  assign busy   = (state != IDLE) || hold;
  assign accept = req_valid && !busy && !flush;
  assign is_mem = (req.op == OP_LOAD) || (req.op == OP_STORE);

  // Element size follows the configured width
  always_comb begin
    case (eew_q)
      E8: begin
        elem_size = 3'd1;
        elem_mask = 4'b0001;
      end
      E16: begin
        elem_size = 3'd2;
        elem_mask = 4'b0011;
      end
      default: begin
        elem_size = 3'd4;
        elem_mask = 4'b1111;
      end
    endcase
  end

  // Lane activity and alignment judged at acceptance
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      act_in[i] = ({1'b0, req.ls_idx} + 9'(i)) < {1'b0, vl_q};
      mis_in[i] = ({1'b0, req.lane_val[i][1:0]} + elem_size) > 3'd4;
    end
  end
  assign acc_in = act_in & ~mis_in;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state  <= IDLE;
      vl_q   <= '0;
      eew_q  <= E32;
      acc_q  <= 1'b0;
      exc_q  <= 1'b0;
      lane_q <= 1'b0;
    end else if (flush) begin
      state <= IDLE;
    end else begin
      state <= next_state;
      if (accept) begin
        acc_q  <= is_mem && acc_in[1];
        exc_q  <= is_mem && |(act_in & mis_in);
        lane_q <= ~acc_in[0];
        // Configuration is live from the next cycle on
        if (req.op == OP_CFG) begin
          vl_q  <= req.cfg_vl;
          eew_q <= req.cfg_eew;
        end
      end else if (state == ACCESS && pready) begin
        lane_q <= 1'b1;
        exc_q  <= exc_q | pslverr;
      end
    end
  end

  // Request copy held for the whole sequence
  always_ff @(posedge CLK) begin
    if (accept) begin
      req_q <= req;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (accept) begin
          next_state = (is_mem && |acc_in) ? PREP : NOTIFY;
        end
      end
      NOTIFY:  next_state = IDLE;
      PREP:    next_state = SETUP;
      SETUP:   next_state = ACCESS;
      ACCESS: begin
        if (pready) begin
          next_state = last_access ? IDLE : SETUP;
        end
      end
      default: next_state = IDLE;
    endcase
  end

  assign last_access = lane_q || !acc_q;

  // A second transfer is always lane 1
  assign nxt_lane = (state == PREP) ? lane_q : 1'b1;
  assign nxt_off  = req_q.lane_val[nxt_lane][1:0];

  // APB payload registered ahead of each setup phase
  always_ff @(posedge CLK) begin
    if (next_state == SETUP) begin
      paddr  <= req_q.lane_val[nxt_lane];
      pwrite <= req_q.op == OP_STORE;
      pwdata <= req_q.st_data[nxt_lane] << {nxt_off, 3'b000};
      pstrb  <= (req_q.op == OP_STORE) ? (elem_mask << nxt_off) : 4'b0000;
    end
  end

  assign psel    = (state == SETUP) || (state == ACCESS);
  assign penable = state == ACCESS;

  always_comb begin
    elem       = '0;
    elem.eew   = eew_q;
    elem.exc   = exc_q;
    elem_valid = 1'b0;
    if (state == NOTIFY) begin
      elem_valid = 1'b1;
      elem.last  = 1'b1;
      elem.wen   = (req_q.op == OP_ALU) ? 2'b11 : 2'b00;
    end else if (state == ACCESS && pready) begin
      elem_valid  = 1'b1;
      elem.lane   = lane_q;
      elem.offset = req_q.lane_val[lane_q][1:0];
      elem.load   = req_q.op == OP_LOAD;
      elem.last   = last_access;
      elem.wen    = (req_q.op == OP_LOAD) ? (2'b01 << lane_q) : 2'b00;
      elem.exc    = exc_q | pslverr;
    end
  end

  // Read data replaces the value of the lane in flight
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      if (state == ACCESS && lane_q == 1'(i)) begin
        lane_data[i] = prdata;
      end else begin
        lane_data[i] = req_q.lane_val[i];
      end
    end
  end

  assign vd_out = req_q.vd;

endmodule

/* design/vmem_scratchpad.sv */
// Zero-wait APB word memory; never flags pslverr, address bits above bit 9 wrap
`timescale 1ns/10ps

module vmem_scratchpad (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] paddr,
  input  logic [31:0] pwdata,
  input  logic [3:0]  pstrb,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);
  import vmem_pkg::*;

  logic [XLEN-1:0]   mem [MEM_WORDS];
  logic [MEM_AW-1:0] widx;
  logic              access;

  // Word index, byte offset dropped
  assign widx   = paddr[2 +: MEM_AW];
  assign access = psel && penable;

  // Strobed byte writes in the access phase
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int w = 0; w < MEM_WORDS; w++) begin
        mem[w] <= '0;
      end
    end else if (access && pwrite) begin
      for (int b = 0; b < XLEN / 8; b++) begin
        if (pstrb[b]) begin
          mem[widx][8*b +: 8] <= pwdata[8*b +: 8];
        end
      end
    end
  end

  // Read word is valid in the same access cycle
  assign prdata = mem[widx];

  // Every transfer completes on its first access cycle
  assign pready  = access;
  assign pslverr = 1'b0;

endmodule

/* design/vmem_load_align.sv */
// Zero extension only; lanes not written in a record read back as zero
`timescale 1ns/10ps

module vmem_load_align (
  input  logic                 CLK,
  input  logic                 nRST,
  input  vmem_pkg::vmem_elem_t elem,
  input  logic                 elem_valid,
  input  logic [1:0][31:0]     lane_data,
  input  logic [4:0]           vd_in,
  input  logic                 flush,
  output vmem_pkg::vmem_wb_t   wb,
  output logic                 wb_valid,
  input  logic                 wb_ready,
  output logic                 hold
);
  import vmem_pkg::*;

  logic [LANES-1:0][XLEN-1:0] buf_q;
  logic [LANES-1:0][XLEN-1:0] data_nxt;
  logic [LANES-1:0]           wen_q;
  logic [LANES-1:0]           wen_nxt;
  logic                       exc_q;
  logic                       exc_nxt;
  logic                       take;

  // Shift element down to bit 0 and clear the bytes above it
  function automatic logic [XLEN-1:0] align_elem(
    input logic [XLEN-1:0] raw,
    input logic [1:0]      off,
    input eew_t            eew
  );
    logic [XLEN-1:0] shifted;
    shifted = raw >> {off, 3'b000};
    case (eew)
      E8:      align_elem = {{(XLEN - 8){1'b0}}, shifted[7:0]};
      E16:     align_elem = {{(XLEN - 16){1'b0}}, shifted[15:0]};
      default: align_elem = shifted;
    endcase
  endfunction

  // Stalled record stays put
  assign hold = wb_valid && !wb_ready;

  // Merge the incoming notice into lanes gathered so far
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      data_nxt[i] = wen_q[i] ? buf_q[i] : '0;
      if (elem_valid && elem.wen[i]) begin
        if (!elem.load) begin
          data_nxt[i] = lane_data[i];
        end else if (elem.lane == 1'(i)) begin
          data_nxt[i] = align_elem(lane_data[i], elem.offset, elem.eew);
        end
      end
    end
    wen_nxt = wen_q | (elem_valid ? elem.wen : '0);
    exc_nxt = exc_q | (elem_valid && elem.exc);
  end

  assign take = elem_valid && elem.last && !hold && !flush;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wen_q    <= '0;
      exc_q    <= 1'b0;
      wb_valid <= 1'b0;
    end else if (flush) begin
      wen_q    <= '0;
      exc_q    <= 1'b0;
      wb_valid <= 1'b0;
    end else begin
      if (wb_valid && wb_ready) begin
        wb_valid <= 1'b0;
      end
      if (elem_valid) begin
        if (elem.last) begin
          wen_q <= '0;
          exc_q <= 1'b0;
          if (!hold) begin
            wb_valid <= 1'b1;
          end
        end else begin
          wen_q <= wen_nxt;
          exc_q <= exc_nxt;
        end
      end
    end
  end

  // Lane buffer, one entry per lane
  always_ff @(posedge CLK) begin
    if (elem_valid && !flush) begin
      buf_q <= data_nxt;
    end
  end

  // Writeback pipeline latch
  always_ff @(posedge CLK) begin
    if (take) begin
      wb.vd   <= vd_in;
      wb.data <= data_nxt;
      wb.wen  <= wen_nxt;
      wb.eew  <= elem.eew;
      wb.exc  <= exc_nxt;
    end
  end

endmodule

/* design/vmem_stage.sv */
// Request must be held only in its acceptance cycle; one request in flight at a time
`timescale 1ns/10ps

module vmem_stage (
  input  logic                CLK,
  input  logic                nRST,
  input  vmem_pkg::vmem_req_t req,
  input  logic                req_valid,
  output logic                busy,
  input  logic                flush,
  output vmem_pkg::vmem_wb_t  wb,
  output logic                wb_valid,
  input  logic                wb_ready
);
  import vmem_pkg::*;

  // APB between scheduler and scratchpad
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] paddr;
  logic [31:0] pwdata;
  logic [3:0]  pstrb;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  // Scheduler to aligner
  vmem_elem_t       elem;
  logic             elem_valid;
  logic [1:0][31:0] lane_data;
  logic [4:0]       vd;
  logic             hold;

  vmem_addr_sched SCHED (
    .CLK        (CLK),
    .nRST       (nRST),
    .req        (req),
    .req_valid  (req_valid),
    .busy       (busy),
    .flush      (flush),
    .hold       (hold),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .pstrb      (pstrb),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .elem       (elem),
    .elem_valid (elem_valid),
    .lane_data  (lane_data),
    .vd_out     (vd)
  );

  vmem_scratchpad SPAD (
    .CLK     (CLK),
    .nRST    (nRST),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  vmem_load_align ALIGN (
    .CLK        (CLK),
    .nRST       (nRST),
    .elem       (elem),
    .elem_valid (elem_valid),
    .lane_data  (lane_data),
    .vd_in      (vd),
    .flush      (flush),
    .wb         (wb),
    .wb_valid   (wb_valid),
    .wb_ready   (wb_ready),
    .hold       (hold)
  );

endmodule

/* tests/vmem_clk_gen.sv */
// 40 ns clock from time zero; reset held low for 5 rising edges, released on a falling edge
`timescale 1ns/10ps

module vmem_clk_gen (
  output logic CLK,
  output logic nRST
);
  localparam int HALF_PERIOD  = 20;
  localparam int RESET_CYCLES = 5;

  initial begin
    CLK = 1'b0;
    forever #(HALF_PERIOD) CLK = ~CLK;
  end

  initial begin
    nRST = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
  end

endmodule

/* tests/vmem_stage_tb.sv */
// Expected records come from a byte-level model; the flushed request must be a load
`timescale 1ns/10ps

module vmem_stage_tb;
  import vmem_pkg::*;

  localparam int RAND_REQS      = 60;
  // Directed requests, rounded up
  localparam int DIRECTED_REQS  = 48;
  localparam int TIMEOUT_CYCLES = (DIRECTED_REQS + RAND_REQS) * 20 + 200;

  logic      CLK;
  logic      nRST;
  vmem_req_t req;
  logic      req_valid;
  logic      busy;
  logic      flush;
  vmem_wb_t  wb;
  logic      wb_valid;
  logic      wb_ready;
  logic      stall_en;

  integer seed            = 32'hb7e3_c0fb;
  integer ready_seed      = 32'hb7e3_c0fb;
  int     mismatch_errors = 0;
  int     other_errors    = 0;
  int     spurious        = 0;
  int     checked         = 0;

  // Model state, byte addressed over the 1 KiB window
  logic [7:0] model_mem [1024];
  logic [7:0] model_vl;
  eew_t       model_eew;
  vmem_wb_t   exp_q[$];
  string      name_q[$];

  vmem_clk_gen CLK_GEN (
    .CLK  (CLK),
    .nRST (nRST)
  );

  vmem_stage UUT (
    .CLK       (CLK),
    .nRST      (nRST),
    .req       (req),
    .req_valid (req_valid),
    .busy      (busy),
    .flush     (flush),
    .wb        (wb),
    .wb_valid  (wb_valid),
    .wb_ready  (wb_ready)
  );

  function automatic vmem_req_t build_req(input vop_t op, input logic [31:0] a0,
                                          input logic [31:0] a1, input logic [31:0] d0,
                                          input logic [31:0] d1, input logic [7:0] idx,
                                          input logic [4:0] vd);
    vmem_req_t r;
    r             = '0;
    r.op          = op;
    r.lane_val[0] = a0;
    r.lane_val[1] = a1;
    r.st_data[0]  = d0;
    r.st_data[1]  = d1;
    r.ls_idx      = idx;
    r.vd          = vd;
    return r;
  endfunction

  function automatic vmem_req_t build_cfg(input logic [7:0] vl, input eew_t eew,
                                          input logic [4:0] vd);
    vmem_req_t r;
    r         = '0;
    r.op      = OP_CFG;
    r.cfg_vl  = vl;
    r.cfg_eew = eew;
    r.vd      = vd;
    return r;
  endfunction

  // Random upper bits exercise address wrap, bits 9:6 cleared to reuse a small window
  function automatic logic [31:0] rand_addr(input logic [1:0] off);
    logic [31:0] a;
    a      = $random(seed);
    a[9:6] = 4'b0000;
    a[1:0] = off;
    return a;
  endfunction

  // Expected writeback record; updates model config and memory as the DUT should
  function automatic vmem_wb_t model_request(input vmem_req_t r);
    vmem_wb_t rec;
    int       size;
    int       off;
    int       base;
    rec    = '0;
    rec.vd = r.vd;
    if (r.op == OP_CFG) begin
      model_vl  = r.cfg_vl;
      model_eew = r.cfg_eew;
    end
    rec.eew = model_eew;
    case (model_eew)
      E8:      size = 1;
      E16:     size = 2;
      default: size = 4;
    endcase
    if (r.op == OP_ALU) begin
      rec.data = r.lane_val;
      rec.wen  = 2'b11;
    end else if (r.op == OP_LOAD || r.op == OP_STORE) begin
      for (int i = 0; i < LANES; i++) begin
        off  = int'(r.lane_val[i][1:0]);
        base = int'(r.lane_val[i][9:0]);
        if (int'(r.ls_idx) + i < int'(model_vl)) begin
          if (off + size > 4) begin
            rec.exc = 1'b1;
          end else if (r.op == OP_STORE) begin
            for (int b = 0; b < size; b++) begin
              model_mem[base + b] = r.st_data[i][8*b +: 8];
            end
          end else begin
            for (int b = 0; b < size; b++) begin
              rec.data[i][8*b +: 8] = model_mem[base + b];
            end
            rec.wen[i] = 1'b1;
          end
        end
      end
    end
    return rec;
  endfunction

  // Offer a request until the DUT accepts it; busy is sampled mid-cycle
  task automatic send(input vmem_req_t r, input string name, input bit keep);
    @(posedge CLK);
    req       <= r;
    req_valid <= 1'b1;
    @(negedge CLK);
    while (busy) @(negedge CLK);
    if (keep) begin
      exp_q.push_back(model_request(r));
      name_q.push_back(name);
    end
    @(posedge CLK);
    req_valid <= 1'b0;
  endtask

  task automatic drain();
    @(negedge CLK);
    while (exp_q.size() != 0 || busy || wb_valid) @(negedge CLK);
  endtask

  initial begin
    wb_ready = 1'b1;
    forever begin
      @(posedge CLK);
      wb_ready <= stall_en ? (2'($random(ready_seed)) != 2'b00) : 1'b1;
    end
  end

  // Compare each handshaked record with the oldest expected one
  always @(negedge CLK) begin : compare
    vmem_wb_t want;
    string    tname;
    if (nRST && wb_valid && wb_ready) begin
      assert (exp_q.size() != 0) else begin
        spurious++;
        $display("writeback record for vd %0d arrived with no request pending", wb.vd);
      end
      if (exp_q.size() != 0) begin
        want  = exp_q.pop_front();
        tname = name_q.pop_front();
        checked++;
        assert (wb === want) else begin
          mismatch_errors++;
          $display("mismatch %s: expected %h, actual %h", tname, want, wb);
        end
      end
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge CLK);
    $display("watchdog expired after %0d cycles, %0d records outstanding, %0d mismatches",
             TIMEOUT_CYCLES, exp_q.size(), mismatch_errors);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    logic [31:0] a0;
    logic [31:0] a1;
    logic [31:0] d0;
    logic [31:0] d1;
    logic [1:0]  pick;
    vop_t        op;
    req       = '0;
    req_valid = 1'b0;
    flush     = 1'b0;
    stall_en  = 1'b0;
    model_vl  = '0;
    model_eew = E32;
    for (int i = 0; i < 1024; i++) begin
      model_mem[i] = '0;
    end
    @(posedge nRST);
    @(negedge CLK);
    assert (!busy && !wb_valid) else begin
      other_errors++;
      $display("busy or wb_valid is high right after reset");
    end

    // Reset config has vl 0, so no lane is active
    send(build_req(OP_LOAD, 32'h10, 32'h14, 32'h0, 32'h0, 8'd0, 5'd1), "reset_vl_zero", 1'b1);
    send(build_cfg(8'd1, E32, 5'd0), "cfg_vl_one", 1'b1);
    send(build_req(OP_LOAD, 32'h10, 32'h14, 32'h0, 32'h0, 8'd0, 5'd2), "cfg_one_lane", 1'b1);
    send(build_cfg(8'd16, E32, 5'd0), "cfg_vl_sixteen", 1'b1);

    repeat (4) begin
      d0 = $random(seed);
      d1 = $random(seed);
      send(build_req(OP_ALU, d0, d1, 32'h0, 32'h0, 8'd0, 5'd3), "alu_pass", 1'b1);
    end

    repeat (4) begin
      a0 = rand_addr(2'd0);
      a1 = rand_addr(2'd0);
      d0 = $random(seed);
      d1 = $random(seed);
      send(build_req(OP_STORE, a0, a1, d0, d1, 8'd0, 5'd4), "word_store", 1'b1);
      send(build_req(OP_LOAD, a0, a1, 32'h0, 32'h0, 8'd0, 5'd5), "word_load", 1'b1);
    end

    // Byte then halfword at every offset; halfword offset 3 is misaligned
    for (int e = 0; e < 2; e++) begin
      send(build_cfg(8'd16, (e == 0) ? E8 : E16, 5'd0), "cfg_narrow", 1'b1);
      for (int off = 0; off < 4; off++) begin
        a0 = rand_addr(2'(off));
        a1 = rand_addr(2'(3 - off));
        d0 = $random(seed);
        d1 = $random(seed);
        send(build_req(OP_STORE, a0, a1, d0, d1, 8'd2, 5'd6), "narrow_store", 1'b1);
        send(build_req(OP_LOAD, a0, a1, 32'h0, 32'h0, 8'd2, 5'd7), "narrow_load", 1'b1);
      end
    end

    send(build_cfg(8'd5, E32, 5'd0), "cfg_vl_five", 1'b1);
    a0 = rand_addr(2'd0);
    a1 = rand_addr(2'd0);
    send(build_req(OP_STORE, a0, a1, 32'hdead_beef, 32'h1234_5678, 8'd4, 5'd8),
         "vl_tail_store", 1'b1);
    send(build_req(OP_LOAD, a0, a1, 32'h0, 32'h0, 8'd4, 5'd9), "vl_tail_load", 1'b1);
    send(build_req(OP_STORE, a0, a1, 32'h0bad_f00d, 32'h5a5a_5a5a, 8'd200, 5'd10),
         "vl_none_store", 1'b1);
    send(build_req(OP_LOAD, a0, a1, 32'h0, 32'h0, 8'd0, 5'd11), "vl_none_check", 1'b1);
    send(build_req(OP_STORE, a0 | 32'h2, a1 | 32'h1, 32'hffff_ffff, 32'hffff_ffff, 8'd0, 5'd12),
         "misaligned_store", 1'b1);
    send(build_req(OP_LOAD, a0, a1, 32'h0, 32'h0, 8'd0, 5'd13), "misaligned_check", 1'b1);
    send(build_req(OP_LOAD, a0 | 32'h3, a1, 32'h0, 32'h0, 8'd0, 5'd14), "misaligned_load", 1'b1);

    stall_en <= 1'b1;
    for (int n = 0; n < RAND_REQS; n++) begin
      if (n == RAND_REQS / 2) begin
        // Flush a load in flight; nothing else is pending then
        drain();
        a0 = rand_addr(2'd0);
        a1 = rand_addr(2'd0);
        send(build_req(OP_LOAD, a0, a1, 32'h0, 32'h0, 8'd0, 5'd31), "flushed_load", 1'b0);
        flush <= 1'b1;
        @(posedge CLK);
        flush <= 1'b0;
        @(negedge CLK);
        assert (!busy && !wb_valid) else begin
          other_errors++;
          $display("busy or wb_valid still high after flush");
        end
      end
      op = vop_t'(2'($random(seed)));
      if (op == OP_CFG) begin
        pick = 2'($random(seed));
        if (pick == 2'd3) begin
          pick = 2'd2;
        end
        send(build_cfg({5'b0, 3'($random(seed))}, eew_t'(pick), 5'(n)), "rand_cfg", 1'b1);
      end else begin
        a0 = rand_addr(2'($random(seed)));
        a1 = rand_addr(2'($random(seed)));
        d0 = $random(seed);
        d1 = $random(seed);
        send(build_req(op, a0, a1, d0, d1, {5'b0, 3'($random(seed))}, 5'(n)), "rand_mix", 1'b1);
      end
    end

    drain();
    $display("checked %0d records: %0d mismatches, %0d other errors",
             checked, mismatch_errors, other_errors + spurious);
    if (mismatch_errors + other_errors + spurious == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* list.f */
design/vmem_pkg.sv
design/vmem_addr_sched.sv
design/vmem_scratchpad.sv
design/vmem_load_align.sv
design/vmem_stage.sv
tests/vmem_clk_gen.sv
tests/vmem_stage_tb.sv

/* Makefile */
VERILATOR := verilator
TOP       := vmem_stage_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -j 0 --timescale 1ns/10ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG) for failure"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "TEST PASSED" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
